//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = riscvTb
FILELIST = list.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- list.f
+incdir+verilog
verilog/riscvPkg.sv
verilog/controlFsm.sv
verilog/progCounter.sv
verilog/execDatapath.sv
verilog/dataCache.sv
verilog/riscvTop.sv
verification/tbMemories.sv
verification/riscvTb.sv

//--- verification/riscvTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscvConfig.svh"

module riscvTb;

	// about 40 instructions at up to 7 cycles, doubled, plus margin
	localparam int TimeoutCycles = 2000;
	localparam int IdxBits = `RISCV_CACHE_INDEX_BITS;

	logic CLK;
	logic rstN;
	logic iMemCsn;
	logic [11:0] iMemAddr;
	logic [31:0] iMemRdata;
	logic dMemCsn;
	logic [11:0] dMemAddr;
	logic [31:0] dMemWdata;
	logic dMemWen;
	logic [3:0] dMemBe;
	logic [31:0] dMemRdata;
	logic rfWe;
	logic [4:0] rfRa1;
	logic [4:0] rfRa2;
	logic [4:0] rfWa;
	logic [31:0] rfWd;
	logic [31:0] rfRd1;
	logic [31:0] rfRd2;
	logic halt;
	logic [31:0] numInst;
	logic [31:0] outputPort;

	// reference model state and expectations
	logic [31:0] prog [$];
	logic [31:0] refMem [4096];
	logic [31:0] refRegs [32];
	bit cValid [1 << IdxBits];
	logic [11-IdxBits:0] cTag [1 << IdxBits];
	logic [4:0] expRd [$];
	logic [31:0] expVal [$];
	int expReads [$];
	logic [11:0] stAddr [$];
	logic [31:0] stData [$];
	logic [11:0] pcTrace [$];
	int refCount;
	int seed;

	int testErr [6];
	int testChecks [6];
	int otherErrors;
	int traceIdx;
	int readCount;
	bit traceStarted;
	bit prevWe;
	logic [11:0] lastAddr;
	logic [31:0] lastWd;

	riscvTop dut0 (
		.CLK(CLK), .rstN(rstN), .iMemCsn(iMemCsn), .iMemAddr(iMemAddr),
		.iMemRdata(iMemRdata), .dMemCsn(dMemCsn), .dMemAddr(dMemAddr),
		.dMemWdata(dMemWdata), .dMemWen(dMemWen), .dMemBe(dMemBe), .dMemRdata(dMemRdata),
		.rfWe(rfWe), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa(rfWa), .rfWd(rfWd),
		.rfRd1(rfRd1), .rfRd2(rfRd2), .halt(halt), .numInst(numInst),
		.outputPort(outputPort)
	);

	tbMemories mem0 (
		.CLK(CLK), .iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .iMemRdata(iMemRdata),
		.dMemCsn(dMemCsn), .dMemWen(dMemWen), .dMemAddr(dMemAddr),
		.dMemWdata(dMemWdata), .dMemRdata(dMemRdata), .rfWe(rfWe), .rfRa1(rfRa1),
		.rfRa2(rfRa2), .rfWa(rfWa), .rfWd(rfWd), .rfRd1(rfRd1), .rfRd2(rfRd2)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// instruction encoders
	function automatic logic [31:0] rOp(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] iOp(int op, int f3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] sOp(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bOp(int f3, int rs1, int rs2, int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] jOp(int rd, int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic check(input int t, input bit ok, input string msg);
		testChecks[t]++;
		assert (ok) else begin
			$display("Fail %0t: %s", $time, msg);
			testErr[t]++;
		end
	endtask

	task automatic buildProgram();
		prog.push_back(iOp(7'h13, 0, 2, 0, 100));
		prog.push_back(iOp(7'h13, 0, 3, 0, -7));
		prog.push_back(rOp(0, 0, 4, 2, 3));
		prog.push_back(rOp(7'h20, 0, 5, 3, 2));
		prog.push_back(rOp(0, 7, 6, 2, 3));
		prog.push_back(rOp(0, 6, 7, 2, 3));
		prog.push_back(rOp(0, 2, 8, 3, 2));
		prog.push_back(rOp(0, 2, 9, 2, 3));
		// miss, hit, conflicting tag, then evicted line again
		prog.push_back(iOp(7'h03, 2, 10, 0, 'h100));
		prog.push_back(iOp(7'h03, 2, 11, 0, 'h100));
		prog.push_back(iOp(7'h03, 2, 12, 0, 'h140));
		prog.push_back(iOp(7'h03, 2, 13, 0, 'h100));
		// store to an uncached word, then store into a cached line
		prog.push_back(sOp(4, 0, 'h104));
		prog.push_back(iOp(7'h03, 2, 14, 0, 'h104));
		prog.push_back(sOp(5, 0, 'h104));
		prog.push_back(iOp(7'h03, 2, 15, 0, 'h104));
		prog.push_back(rOp(0, 0, 16, 10, 11));
		prog.push_back(bOp(0, 2, 2, 8));
		prog.push_back(iOp(7'h13, 0, 17, 0, 1));
		prog.push_back(bOp(1, 2, 2, 8));
		prog.push_back(iOp(7'h13, 0, 18, 0, 5));
		prog.push_back(bOp(1, 2, 3, 8));
		prog.push_back(iOp(7'h13, 0, 19, 0, 2));
		prog.push_back(bOp(0, 2, 3, 8));
		prog.push_back(jOp(20, 12));
		prog.push_back(iOp(7'h13, 0, 21, 0, 3));
		prog.push_back(iOp(7'h13, 0, 22, 0, 4));
		prog.push_back(rOp(0, 0, 23, 16, 12));
		prog.push_back(sOp(23, 0, 'h200));
		prog.push_back(iOp(7'h03, 2, 24, 0, 'h200));
		prog.push_back(rOp(0, 6, 25, 24, 3));
		prog.push_back(rOp(7'h20, 0, 26, 25, 13));
		prog.push_back(iOp(7'h13, 0, 27, 26, -1));
		prog.push_back(sOp(27, 0, 'h7fc));
		prog.push_back(rOp(0, 7, 28, 27, 15));
		prog.push_back(iOp(7'h13, 0, 1, 0, 12));
		prog.push_back(`RISCV_HALT_INST);
	endtask

	// interprets the program straight from the RV32I encoding
	task automatic runModel();
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		logic [31:0] addr;
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [11:0] w;
		int reads;
		bit wr;
		pc = 32'h0;
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = 32'h0;
		end
		for (int step = 0; step < 1000; step++) begin
			ins = prog[pc[11:2]];
			pcTrace.push_back(pc[11:0]);
			if (ins == `RISCV_HALT_INST && refRegs[1] == `RISCV_HALT_RA) begin
				break;
			end
			a = refRegs[ins[19:15]];
			b = refRegs[ins[24:20]];
			immI = {{20{ins[31]}}, ins[31:20]};
			immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			nextPc = pc + 32'd4;
			wr = 1'b1;
			reads = 0;
			val = 32'h0;
			case (ins[6:0])
				7'h33: begin
					case (ins[14:12])
						3'd0: val = ins[30] ? a - b : a + b;
						3'd2: val = {31'd0, $signed(a) < $signed(b)};
						3'd6: val = a | b;
						default: val = a & b;
					endcase
				end
				7'h13: val = a + immI;
				7'h03: begin
					addr = a + immI;
					w = addr[13:2];
					if (!(cValid[w[IdxBits-1:0]] && cTag[w[IdxBits-1:0]] == w[11:IdxBits])) begin
						reads = 1;
					end
					cValid[w[IdxBits-1:0]] = 1'b1;
					cTag[w[IdxBits-1:0]] = w[11:IdxBits];
					val = refMem[w];
				end
				7'h23: begin
					addr = a + immS;
					w = addr[13:2];
					refMem[w] = b;
					stAddr.push_back(w);
					stData.push_back(b);
					wr = 1'b0;
				end
				7'h63: begin
					wr = 1'b0;
					// funct3 bit 0 turns beq into bne
					if ((a == b) != ins[12]) begin
						nextPc = pc + immB;
					end
				end
				default: begin
					val = pc + 32'd4;
					nextPc = pc + immJ;
				end
			endcase
			if (wr) begin
				expRd.push_back(ins[11:7]);
				expVal.push_back(val);
				expReads.push_back(reads);
				if (ins[11:7] != 5'd0) begin
					refRegs[ins[11:7]] = val;
				end
			end
			refCount++;
			pc = nextPc;
		end
	endtask

	// bus monitor, sampled on the rising edge
	always @(posedge CLK) begin
		if (rstN) begin
			if (!traceStarted || iMemAddr != lastAddr) begin
				if (!traceStarted) begin
					check(0, iMemAddr == `RISCV_RESET_PC, "first fetch address after reset");
				end
				check(4, !iMemCsn, $sformatf("instruction memory not selected for fetch at %h",
					iMemAddr));
				if (traceIdx < pcTrace.size()) begin
					check(4, iMemAddr == pcTrace[traceIdx],
						$sformatf("fetch %0d at %h, expected %h", traceIdx, iMemAddr,
						pcTrace[traceIdx]));
				end else begin
					$display("Fetch address %h is beyond the expected program flow", iMemAddr);
					otherErrors++;
				end
				traceStarted = 1'b1;
				traceIdx++;
				lastAddr = iMemAddr;
			end
			if (prevWe) begin
				check(1, outputPort == lastWd, $sformatf("outputPort %h, last write %h",
					outputPort, lastWd));
			end
			prevWe = rfWe;
			if (rfWe) begin
				if (expRd.size() == 0) begin
					$display("Register write to x%0d arrived after the last expected one", rfWa);
					otherErrors++;
				end else begin
					check(1, rfWa == expRd[0] && rfWd == expVal[0],
						$sformatf("write x%0d=%h, expected x%0d=%h", rfWa, rfWd, expRd[0],
						expVal[0]));
					check(3, readCount == expReads[0],
						$sformatf("%0d memory reads for x%0d, expected %0d", readCount,
						rfWa, expReads[0]));
					void'(expRd.pop_front());
					void'(expVal.pop_front());
					void'(expReads.pop_front());
				end
				lastWd = rfWd;
				readCount = 0;
			end
			if (!dMemCsn) begin
				check(2, dMemBe == 4'b1111, $sformatf("byte enables %b on a data access",
					dMemBe));
			end
			if (!dMemCsn && dMemWen) begin
				readCount++;
			end
			if (!dMemCsn && !dMemWen) begin
				if (stAddr.size() == 0) begin
					$display("Data memory write at %h arrived after the last store", dMemAddr);
					otherErrors++;
				end else begin
					check(2, dMemAddr == stAddr[0] && dMemWdata == stData[0],
						$sformatf("store %h to %h, expected %h to %h", dMemWdata, dMemAddr,
						stData[0], stAddr[0]));
					void'(stAddr.pop_front());
					void'(stData.pop_front());
				end
			end
		end
	end

	initial begin
		for (int c = 0; c < TimeoutCycles; c++) begin
			@(posedge CLK);
		end
		$display("Timeout: halt did not rise within %0d cycles", TimeoutCycles);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		int errors;
		int checks;
		int memBad;
		rstN = 1'b0;
		seed = 32'h20a4;
		buildProgram();
		for (int i = 0; i < 1024; i++) begin
			mem0.imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
		end
		for (int i = 0; i < 4096; i++) begin
			refMem[i] = $random(seed);
			mem0.dmem[i] = refMem[i];
		end
		runModel();

		// the first edge only settles the state
		@(posedge CLK);
		repeat (7) begin
			@(posedge CLK);
			check(0, !rfWe && dMemWen && dMemCsn && !halt && numInst == 32'd0,
				"outputs not idle during reset");
		end
		rstN <= 1'b1;
		// the monitor checks the first fetch address
		wait (traceStarted);
		$display("test reset: %0d checks, %0d errors", testChecks[0], testErr[0]);

		while (!halt) begin
			@(posedge CLK);
		end
		check(5, numInst == refCount, $sformatf("numInst %0d, expected %0d", numInst,
			refCount));
		check(5, expRd.size() == 0, "register writes missing at halt");
		check(5, stAddr.size() == 0, "stores missing at halt");
		// the core must stay quiet once halted
		repeat (20) @(posedge CLK);
		check(5, halt && numInst == refCount, "core moved after halt");
		memBad = 0;
		for (int i = 0; i < 4096; i++) begin
			if (mem0.dmem[i] != refMem[i]) begin
				memBad++;
			end
		end
		check(5, memBad == 0, $sformatf("%0d data memory words differ", memBad));

		$display("test register writes: %0d checks, %0d errors", testChecks[1], testErr[1]);
		$display("test stores: %0d checks, %0d errors", testChecks[2], testErr[2]);
		$display("test cache reads: %0d checks, %0d errors", testChecks[3], testErr[3]);
		$display("test fetch trace: %0d checks, %0d errors", testChecks[4], testErr[4]);
		$display("test halt: %0d checks, %0d errors", testChecks[5], testErr[5]);
		errors = otherErrors;
		checks = 0;
		for (int t = 0; t < 6; t++) begin
			errors += testErr[t];
			checks += testChecks[t];
		end
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tbMemories.sv
`timescale 1ns/10ps
`default_nettype none

module tbMemories (
	input wire logic CLK,
	input wire logic iMemCsn,
	input wire logic [11:0] iMemAddr,
	output logic [31:0] iMemRdata,
	input wire logic dMemCsn,
	input wire logic dMemWen,
	input wire logic [11:0] dMemAddr,
	input wire logic [31:0] dMemWdata,
	output logic [31:0] dMemRdata,
	input wire logic rfWe,
	input wire logic [4:0] rfRa1,
	input wire logic [4:0] rfRa2,
	input wire logic [4:0] rfWa,
	input wire logic [31:0] rfWd,
	output logic [31:0] rfRd1,
	output logic [31:0] rfRd2
);

	// contents are loaded by the testbench top
	logic [31:0] imem [1024];
	logic [31:0] dmem [4096];
	logic [31:0] regs [32];

	initial begin
		iMemRdata = 32'h0;
		dMemRdata = 32'h0;
		for (int i = 0; i < 32; i++) begin
			regs[i] = 32'h0;
		end
	end

	// synchronous reads, data one edge after the address
	always @(posedge CLK) begin
		if (!iMemCsn) begin
			iMemRdata <= imem[iMemAddr[11:2]];
		end
		if (!dMemCsn) begin
			if (!dMemWen) begin
				dmem[dMemAddr] <= dMemWdata;
			end else begin
				dMemRdata <= dmem[dMemAddr];
			end
		end
	end

	// x0 is never written
	always @(posedge CLK) begin
		if (rfWe && rfWa != 5'd0) begin
			regs[rfWa] <= rfWd;
		end
	end

	assign rfRd1 = regs[rfRa1];
	assign rfRd2 = regs[rfRa2];

endmodule

`default_nettype wire

//--- verilog/controlFsm.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscvConfig.svh"

module controlFsm (
	input wire logic CLK,
	input wire logic rstN,
	input wire riscvPkg::wordT instr,
	input wire riscvPkg::wordT rfRd1,
	input wire logic cmpTrue,
	input wire logic stall,
	output logic irLoad,
	output logic opLoad,
	output riscvPkg::aluOpT aluOp,
	output logic aluSrcA,
	output logic aluSrcB,
	output riscvPkg::immSelT immSel,
	output riscvPkg::wbSelT wbSel,
	output logic rfWe,
	output logic memRead,
	output logic memWrite,
	output logic pcWrite,
	output logic pcSel,
	output logic retire,
	output logic halt
);

	localparam logic [6:0] OpReg = 7'b0110011;
	localparam logic [6:0] OpImm = 7'b0010011;
	localparam logic [6:0] OpLoad = 7'b0000011;
	localparam logic [6:0] OpStore = 7'b0100011;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpJal = 7'b1101111;

	riscvPkg::cpuStateT state;
	riscvPkg::cpuStateT nextState;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic isJal;
	logic isHalt;
	logic branchTaken;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign isLoad = (opcode == OpLoad);
	assign isStore = (opcode == OpStore);
	assign isBranch = (opcode == OpBranch);
	assign isJal = (opcode == OpJal);
	assign isHalt = (instr == `RISCV_HALT_INST) && (rfRd1 == `RISCV_HALT_RA);
	// funct3[0] set means bne
	assign branchTaken = funct3[0] ? !cmpTrue : cmpTrue;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= riscvPkg::stFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			riscvPkg::stFetch: nextState = riscvPkg::stDecode;
			riscvPkg::stDecode: begin
				if (isHalt) begin
					nextState = riscvPkg::stHalted;
				end else begin
					nextState = riscvPkg::stExecute;
				end
			end
			riscvPkg::stExecute: begin
				if (isBranch) begin
					nextState = riscvPkg::stFetch;
				end else if (isLoad || isStore) begin
					nextState = riscvPkg::stMemory;
				end else begin
					nextState = riscvPkg::stWriteBack;
				end
			end
			riscvPkg::stMemory: begin
				// wait out a cache fill
				if (!stall) begin
					nextState = isLoad ? riscvPkg::stWriteBack : riscvPkg::stFetch;
				end
			end
			riscvPkg::stWriteBack: nextState = riscvPkg::stFetch;
			default: nextState = riscvPkg::stHalted;
		endcase
	end

	// operand and immediate selects follow the opcode
	always_comb begin
		aluSrcA = 1'b0;
		aluSrcB = 1'b1;
		aluOp = riscvPkg::aluAdd;
		immSel = riscvPkg::immI;
		wbSel = riscvPkg::wbAlu;
		case (opcode)
			OpReg: begin
				aluSrcB = 1'b0;
				case (funct3)
					3'b000: aluOp = instr[30] ? riscvPkg::aluSub : riscvPkg::aluAdd;
					3'b010: aluOp = riscvPkg::aluSlt;
					3'b110: aluOp = riscvPkg::aluOr;
					3'b111: aluOp = riscvPkg::aluAnd;
					default: aluOp = riscvPkg::aluAdd;
				endcase
			end
			OpLoad: wbSel = riscvPkg::wbLoad;
			OpStore: immSel = riscvPkg::immS;
			OpBranch: begin
				aluSrcB = 1'b0;
				aluOp = riscvPkg::aluEq;
				immSel = riscvPkg::immB;
			end
			OpJal: begin
				aluSrcA = 1'b1;
				immSel = riscvPkg::immJ;
				wbSel = riscvPkg::wbPc4;
			end
			default: aluOp = riscvPkg::aluAdd;
		endcase
		// decode uses the ALU for pc + imm, kept as the target
		if (state == riscvPkg::stDecode) begin
			aluSrcA = 1'b1;
			aluSrcB = 1'b1;
			aluOp = riscvPkg::aluAdd;
		end
	end

	assign irLoad = (state == riscvPkg::stDecode);
	assign opLoad = (state == riscvPkg::stDecode);
	assign memRead = (state == riscvPkg::stMemory) && isLoad;
	assign memWrite = (state == riscvPkg::stMemory) && isStore;
	assign rfWe = (state == riscvPkg::stWriteBack);
	assign halt = (state == riscvPkg::stHalted);

	// last state of every instruction moves the pc
	always_comb begin
		retire = 1'b0;
		pcSel = 1'b0;
		case (state)
			riscvPkg::stExecute: begin
				retire = isBranch;
				pcSel = branchTaken;
			end
			riscvPkg::stMemory: retire = isStore && !stall;
			riscvPkg::stWriteBack: begin
				retire = 1'b1;
				pcSel = isJal;
			end
			default: retire = 1'b0;
		endcase
	end

	assign pcWrite = retire;

endmodule

`default_nettype wire

//--- verilog/dataCache.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscvConfig.svh"

module dataCache (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic memRead,
	input wire logic memWrite,
	input wire riscvPkg::dAddrT addr,
	input wire riscvPkg::wordT wdata,
	input wire riscvPkg::wordT dMemRdata,
	output riscvPkg::wordT rdata,
	output logic stall,
	output logic dMemCsn,
	output logic dMemWen,
	output riscvPkg::dAddrT dMemAddr,
	output riscvPkg::wordT dMemWdata
);

	localparam int IndexBits = `RISCV_CACHE_INDEX_BITS;
	localparam int TagBits = 12 - IndexBits;
	localparam int Lines = 1 << IndexBits;

	logic valid [Lines];
	logic [TagBits-1:0] tags [Lines];
	riscvPkg::wordT words [Lines];

	logic [IndexBits-1:0] index;
	logic [TagBits-1:0] tag;
	logic hit;
	logic missRead;
	logic fillPending;

	assign index = addr[IndexBits-1:0];
	assign tag = addr[11:IndexBits];
	assign hit = valid[index] && (tags[index] == tag);

	// a miss issues the read now, data lands next cycle
	assign missRead = memRead && !hit && !fillPending;
	assign stall = missRead || fillPending;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			fillPending <= 1'b0;
		end else begin
			fillPending <= missRead;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < Lines; i++) begin
				valid[i] <= 1'b0;
			end
		end else if (fillPending) begin
			valid[index] <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (fillPending) begin
			tags[index] <= tag;
			words[index] <= dMemRdata;
		end else if (memWrite && hit) begin
			// no write allocate, only a hit line is refreshed
			words[index] <= wdata;
		end
	end

	assign rdata = words[index];

	// every write goes straight through to memory
	assign dMemCsn = !(missRead || memWrite);
	assign dMemWen = !memWrite;
	assign dMemAddr = addr;
	assign dMemWdata = wdata;

endmodule

`default_nettype wire

//--- verilog/execDatapath.sv
`timescale 1ns/10ps
`default_nettype none

module execDatapath (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic irLoad,
	input wire logic opLoad,
	input wire riscvPkg::wordT iMemRdata,
	input wire riscvPkg::iAddrT pc,
	input wire riscvPkg::wordT rfRd1,
	input wire riscvPkg::wordT rfRd2,
	input wire riscvPkg::aluOpT aluOp,
	input wire logic aluSrcA,
	input wire logic aluSrcB,
	input wire riscvPkg::immSelT immSel,
	input wire riscvPkg::wbSelT wbSel,
	input wire riscvPkg::wordT loadData,
	input wire logic rfWe,
	output riscvPkg::wordT instr,
	output riscvPkg::regAddrT rfRa1,
	output riscvPkg::regAddrT rfRa2,
	output riscvPkg::regAddrT rfWa,
	output riscvPkg::wordT rfWd,
	output riscvPkg::wordT storeData,
	output riscvPkg::dAddrT memAddr,
	output riscvPkg::iAddrT target,
	output logic cmpTrue,
	output riscvPkg::wordT outputPort
);

	riscvPkg::wordT ir;
	riscvPkg::wordT opA;
	riscvPkg::wordT opB;
	riscvPkg::wordT imm;
	riscvPkg::wordT aluA;
	riscvPkg::wordT aluB;
	riscvPkg::wordT aluOut;
	riscvPkg::wordT result;
	riscvPkg::wordT pcPlus4;

	// memory data is live in decode, the register holds it afterwards
	assign instr = irLoad ? iMemRdata : ir;

	always_ff @(posedge CLK) begin
		if (irLoad) begin
			ir <= iMemRdata;
		end
		if (opLoad) begin
			opA <= rfRd1;
			opB <= rfRd2;
		end
		// reloaded every cycle, inputs stay put after decode
		result <= aluOut;
	end

	assign rfRa1 = instr[19:15];
	assign rfRa2 = instr[24:20];
	assign rfWa = instr[11:7];

	always_comb begin
		case (immSel)
			riscvPkg::immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			riscvPkg::immB: begin
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			riscvPkg::immJ: begin
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	assign aluA = aluSrcA ? {20'd0, pc} : opA;
	assign aluB = aluSrcB ? imm : opB;

	always_comb begin
		case (aluOp)
			riscvPkg::aluSub: aluOut = aluA - aluB;
			riscvPkg::aluAnd: aluOut = aluA & aluB;
			riscvPkg::aluOr: aluOut = aluA | aluB;
			riscvPkg::aluSlt: aluOut = {31'd0, $signed(aluA) < $signed(aluB)};
			riscvPkg::aluEq: aluOut = {31'd0, aluA == aluB};
			default: aluOut = aluA + aluB;
		endcase
	end

	assign cmpTrue = aluOut[0];

	// result holds pc + imm from decode through a branch execute
	assign target = result[11:0];
	assign memAddr = result[13:2];
	assign storeData = opB;

	assign pcPlus4 = {20'd0, pc + 12'd4};

	always_comb begin
		case (wbSel)
			riscvPkg::wbLoad: rfWd = loadData;
			riscvPkg::wbPc4: rfWd = pcPlus4;
			default: rfWd = result;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			outputPort <= '0;
		end else if (rfWe) begin
			outputPort <= rfWd;
		end
	end

endmodule

`default_nettype wire

//--- verilog/progCounter.sv
`timescale 1ns/10ps
`default_nettype none
`include "riscvConfig.svh"

module progCounter (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic pcWrite,
	input wire logic pcSel,
	input wire riscvPkg::iAddrT target,
	input wire logic retire,
	output riscvPkg::iAddrT pc,
	output riscvPkg::wordT numInst
);

	riscvPkg::iAddrT nextPc;

	// pcSel picks the branch or jump target
	assign nextPc = pcSel ? target : pc + 12'd4;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= `RISCV_RESET_PC;
		end else if (pcWrite) begin
			pc <= nextPc;
		end
	end

	// retired instruction count
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			numInst <= '0;
		end else if (retire) begin
			numInst <= numInst + 32'd1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/riscvConfig.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// first fetch address after reset
`define RISCV_RESET_PC 12'h000

// halt is jalr x0, 0(x1) with x1 at the halt return address
`define RISCV_HALT_INST 32'h00008067
`define RISCV_HALT_RA 32'h0000000c

// 16 one-word lines
`define RISCV_CACHE_INDEX_BITS 4

`endif

//--- verilog/riscvPkg.sv
`default_nettype none

package riscvPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;
	// byte address into instruction memory
	typedef logic [11:0] iAddrT;
	// word address into data memory
	typedef logic [11:0] dAddrT;

	typedef enum logic [2:0] {
		stFetch,
		stDecode,
		stExecute,
		stMemory,
		stWriteBack,
		stHalted
	} cpuStateT;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluEq} aluOpT;

	typedef enum logic [1:0] {immI, immS, immB, immJ} immSelT;

	typedef enum logic [1:0] {wbAlu, wbLoad, wbPc4} wbSelT;

endpackage

`default_nettype wire

//--- verilog/riscvTop.sv
`timescale 1ns/10ps
`default_nettype none

module riscvTop (
	input wire logic CLK,
	input wire logic rstN,
	output logic iMemCsn,
	output riscvPkg::iAddrT iMemAddr,
	input wire riscvPkg::wordT iMemRdata,
	output logic dMemCsn,
	output riscvPkg::dAddrT dMemAddr,
	output riscvPkg::wordT dMemWdata,
	output logic dMemWen,
	output logic [3:0] dMemBe,
	input wire riscvPkg::wordT dMemRdata,
	output logic rfWe,
	output riscvPkg::regAddrT rfRa1,
	output riscvPkg::regAddrT rfRa2,
	output riscvPkg::regAddrT rfWa,
	output riscvPkg::wordT rfWd,
	input wire riscvPkg::wordT rfRd1,
	input wire riscvPkg::wordT rfRd2,
	output logic halt,
	output riscvPkg::wordT numInst,
	output riscvPkg::wordT outputPort
);

	riscvPkg::wordT instr;
	riscvPkg::wordT loadData;
	riscvPkg::wordT storeData;
	riscvPkg::dAddrT memAddr;
	riscvPkg::iAddrT pc;
	riscvPkg::iAddrT target;
	riscvPkg::aluOpT aluOp;
	riscvPkg::immSelT immSel;
	riscvPkg::wbSelT wbSel;
	logic irLoad;
	logic opLoad;
	logic aluSrcA;
	logic aluSrcB;
	logic memRead;
	logic memWrite;
	logic pcWrite;
	logic pcSel;
	logic retire;
	logic cmpTrue;
	logic stall;

	// word accesses only
	assign dMemBe = 4'b1111;
	// instruction fetch stops once halted
	assign iMemCsn = halt;
	assign iMemAddr = pc;

	controlFsm ctrl0 (
		.CLK(CLK), .rstN(rstN), .instr(instr), .rfRd1(rfRd1), .cmpTrue(cmpTrue),
		.stall(stall), .irLoad(irLoad), .opLoad(opLoad), .aluOp(aluOp),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .immSel(immSel), .wbSel(wbSel),
		.rfWe(rfWe), .memRead(memRead), .memWrite(memWrite), .pcWrite(pcWrite),
		.pcSel(pcSel), .retire(retire), .halt(halt)
	);

	progCounter pc0 (
		.CLK(CLK), .rstN(rstN), .pcWrite(pcWrite), .pcSel(pcSel), .target(target),
		.retire(retire), .pc(pc), .numInst(numInst)
	);

	execDatapath dp0 (
		.CLK(CLK), .rstN(rstN), .irLoad(irLoad), .opLoad(opLoad),
		.iMemRdata(iMemRdata), .pc(pc), .rfRd1(rfRd1), .rfRd2(rfRd2),
		.aluOp(aluOp), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .immSel(immSel),
		.wbSel(wbSel), .loadData(loadData), .rfWe(rfWe), .instr(instr),
		.rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa(rfWa), .rfWd(rfWd),
		.storeData(storeData), .memAddr(memAddr), .target(target),
		.cmpTrue(cmpTrue), .outputPort(outputPort)
	);

	dataCache cache0 (
		.CLK(CLK), .rstN(rstN), .memRead(memRead), .memWrite(memWrite),
		.addr(memAddr), .wdata(storeData), .dMemRdata(dMemRdata), .rdata(loadData),
		.stall(stall), .dMemCsn(dMemCsn), .dMemWen(dMemWen), .dMemAddr(dMemAddr),
		.dMemWdata(dMemWdata)
	);

endmodule

`default_nettype wire
